/* lsu_pipe.f */
source/lsu_pkg.sv
source/lsu_pipe_ctrl.sv
source/lsu_agen.sv
source/lsu_fwd_align.sv
source/lsu_load_format.sv
source/lsu_pipe.sv
test/lsu_pipe_props.sv
test/lsu_pipe_tb.sv

/* Bender.yml */
package:
  name: lsu_pipe

sources:
  - source/lsu_pkg.sv
  - source/lsu_pipe_ctrl.sv
  - source/lsu_agen.sv
  - source/lsu_fwd_align.sv
  - source/lsu_load_format.sv
  - source/lsu_pipe.sv
  - target: test
    files:
      - test/lsu_pipe_props.sv
      - test/lsu_pipe_tb.sv

/* test/lsu_pipe_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_pipe_tb
  import lsu_pkg::*;
();

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 4;
  localparam int          NUM_ITEMS    = 400;
  localparam int          DRAIN_CYCLES = 4;
  localparam int          WATCHDOG_NS  = (RESET_CYCLES + NUM_ITEMS + DRAIN_CYCLES + 50) * CLK_PERIOD;
  localparam logic [31:0] SEED         = 32'hc634c092;

  typedef struct packed {
    logic      valid;
    inst_t     inst;
    rnid_t     rs1;
    rnid_t     rs2;
    rnid_t     rd;
    mem_q_oh_t qidx;
    rs_oh_t    rsidx;
    paddr_t    paddr;
  } item_t;

  logic      i_clk = 1'b0;
  logic      i_reset_n;
  logic      i_rv_valid;
  inst_t     i_rv_inst;
  rnid_t     i_rv_rs1_rnid, i_rv_rs2_rnid, i_rv_rd_rnid;
  rs_oh_t    i_rv_index_oh;
  logic      i_replay_valid;
  inst_t     i_replay_inst;
  rnid_t     i_replay_rs1_rnid, i_replay_rs2_rnid, i_replay_rd_rnid;
  mem_q_oh_t i_replay_index_oh;
  logic      o_ex0_rs_conflicted;
  rs_oh_t    o_ex0_rs_conf_index_oh;
  rnid_t     o_ex1_rs1_rnid, o_ex1_rs2_rnid;
  xlen_t     i_ex1_rs1_data, i_ex1_rs2_data;
  logic      o_ex1_l1d_valid;
  paddr_t    o_ex1_l1d_paddr;
  logic      i_ex2_l1d_hit, i_ex2_l1d_conflict;
  line_t     i_ex2_l1d_data;
  logic      o_ex1_upd_valid;
  mem_q_oh_t o_ex1_upd_index_oh;
  paddr_t    o_ex1_upd_paddr;
  size_e     o_ex1_upd_size;
  xlen_t     o_ex1_upd_st_data;
  logic      o_ex2_fwd_valid;
  paddr_t    o_ex2_fwd_paddr;
  byte_en_t  o_ex2_fwd_dw;
  byte_en_t  i_ex2_stq_fwd_dw, i_ex2_stbuf_fwd_dw;
  xlen_t     i_ex2_stq_fwd_data, i_ex2_stbuf_fwd_data;
  logic      o_ex2_upd_valid;
  mem_q_oh_t o_ex2_upd_index_oh;
  hazard_e   o_ex2_upd_hazard;
  logic      o_ex2_mispred_valid;
  rnid_t     o_ex2_mispred_rnid;
  logic      o_ex3_done, o_ex3_wr_valid;
  rnid_t     o_ex3_wr_rnid;
  xlen_t     o_ex3_wr_data;

  xlen_t     regs [64];  // Register model, indexed by rename id
  item_t     m_ex0, m_ex1, m_ex2;
  logic      m_ex3_done, m_ex3_wr;
  rnid_t     m_ex3_rd;
  xlen_t     m_ex3_data;
  int        err_count = 0;

  lsu_pipe lsu_pipe_i (.*);

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  assign i_ex1_rs1_data = regs[o_ex1_rs1_rnid];
  assign i_ex1_rs2_data = regs[o_ex1_rs2_rnid];

  // ----------------------------------------
  // Models and helpers
  // ----------------------------------------
  function automatic logic [7:0] mem_byte(input paddr_t a);
    return a[7:0] ^ {a[14:8], a[15]} ^ {a[21:16], a[23:22]} ^ a[31:24] ^
           {a[35:32], a[39:36]} ^ 8'ha5;
  endfunction

  function automatic logic is_store(input inst_t inst);
    return inst[6:0] == 7'b0100011;
  endfunction

  function automatic paddr_t model_paddr(input item_t it);
    xlen_t imm;
    if (is_store(it.inst))
      imm = {{52{it.inst[31]}}, it.inst[31:25], it.inst[11:7]};  // S-type
    else
      imm = {{52{it.inst[31]}}, it.inst[31:20]};
    return paddr_t'(regs[it.rs1] + imm);
  endfunction

  function automatic byte_en_t model_dw(input item_t it);
    int nbytes;
    nbytes = 1 << it.inst[13:12];
    return byte_en_t'(((1 << nbytes) - 1) << it.paddr[2:0]);
  endfunction

  // STQ first, then STBUF, then memory, per byte
  function automatic xlen_t model_load(input item_t it, input byte_en_t stq_dw,
                                       input xlen_t stq_data, input byte_en_t sb_dw,
                                       input xlen_t sb_data);
    xlen_t val;
    int    nbytes;
    int    k;
    val    = '0;
    nbytes = 1 << it.inst[13:12];
    for (int i = 0; i < nbytes; i++) begin
      k = it.paddr[2:0] + i;
      if (stq_dw[k])
        val[i*8 +: 8] = stq_data[k*8 +: 8];
      else if (sb_dw[k])
        val[i*8 +: 8] = sb_data[k*8 +: 8];
      else
        val[i*8 +: 8] = mem_byte(it.paddr + paddr_t'(i));
    end
    if (!it.inst[14] && nbytes < 8 && val[nbytes*8-1]) begin
      for (int i = nbytes; i < 8; i++)
        val[i*8 +: 8] = 8'hff;
    end
    return val;
  endfunction

  // Random load or store, naturally aligned
  task automatic make_item(output item_t it);
    logic       st;
    logic [2:0] f3;
    logic [2:0] off;
    logic [11:0] imm;
    logic [4:0] rd_f;
    int         nbytes;
    it       = '0;
    it.valid = 1'b1;
    st       = ($urandom % 3) == 0;
    f3       = st ? 3'($urandom % 4) : 3'($urandom % 7);
    nbytes   = 1 << f3[1:0];
    it.rs1   = rnid_t'($urandom);
    it.rs2   = rnid_t'($urandom);
    it.rd    = rnid_t'($urandom);
    it.qidx  = mem_q_oh_t'(1) << ($urandom % MEM_Q_SIZE);
    it.rsidx = rs_oh_t'(1) << ($urandom % RV_ENTRY_SIZE);
    off      = 3'($urandom) & ~3'(nbytes - 1);
    imm      = 12'($urandom);
    imm[2:0] = off - regs[it.rs1][2:0];
    rd_f     = (($urandom % 8) == 0) ? 5'd0 : 5'($urandom);
    if (st)
      it.inst = {imm[11:5], 5'($urandom), 5'($urandom), f3, imm[4:0], 7'b0100011};
    else
      it.inst = {imm, 5'($urandom), f3, rd_f, 7'b0000011};
  endtask

  task automatic check_value(input string what, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      err_count++;
      $display("ERR %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("Errors found");
    $fatal(1, "Timeout");
  end

  // ----------------------------------------
  // Stimulus and checking
  // ----------------------------------------
  initial begin
    item_t      new_issue;
    item_t      new_replay;
    item_t      sel;
    logic       hit;
    logic       conflict;
    logic       load2;
    logic       conf2;
    logic       miss2;
    logic       req_valid;
    paddr_t     req_paddr;
    logic [1:0] exp_haz;

    void'($urandom(SEED));
    i_reset_n            = 1'b0;
    i_rv_valid           = 1'b0;
    i_rv_inst            = '0;
    i_rv_rs1_rnid        = '0;
    i_rv_rs2_rnid        = '0;
    i_rv_rd_rnid         = '0;
    i_rv_index_oh        = '0;
    i_replay_valid       = 1'b0;
    i_replay_inst        = '0;
    i_replay_rs1_rnid    = '0;
    i_replay_rs2_rnid    = '0;
    i_replay_rd_rnid     = '0;
    i_replay_index_oh    = '0;
    i_ex2_l1d_hit        = 1'b0;
    i_ex2_l1d_conflict   = 1'b0;
    i_ex2_l1d_data       = '0;
    i_ex2_stq_fwd_dw     = '0;
    i_ex2_stq_fwd_data   = '0;
    i_ex2_stbuf_fwd_dw   = '0;
    i_ex2_stbuf_fwd_data = '0;
    for (int r = 0; r < 64; r++)
      regs[r] = {$urandom, $urandom};
    m_ex0      = '0;
    m_ex1      = '0;
    m_ex2      = '0;
    m_ex3_done = 1'b0;
    m_ex3_wr   = 1'b0;
    m_ex3_rd   = '0;
    m_ex3_data = '0;
    req_valid  = 1'b0;
    req_paddr  = '0;

    repeat (RESET_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    for (int cyc = 0; cyc < NUM_ITEMS + DRAIN_CYCLES; cyc++) begin
      new_issue  = '0;
      new_replay = '0;
      if (cyc < NUM_ITEMS) begin
        if (($urandom % 10) < 6)
          make_item(new_issue);
        if (($urandom % 4) == 0)
          make_item(new_replay);
      end
      i_rv_valid        = new_issue.valid;
      i_rv_inst         = new_issue.inst;
      i_rv_rs1_rnid     = new_issue.rs1;
      i_rv_rs2_rnid     = new_issue.rs2;
      i_rv_rd_rnid      = new_issue.rd;
      i_rv_index_oh     = new_issue.rsidx;
      i_replay_valid    = new_replay.valid;
      i_replay_inst     = new_replay.inst;
      i_replay_rs1_rnid = new_replay.rs1;
      i_replay_rs2_rnid = new_replay.rs2;
      i_replay_rd_rnid  = new_replay.rd;
      i_replay_index_oh = new_replay.qidx;

      // L1D answers last cycle's request
      hit                = ($urandom % 10) < 7;
      conflict           = ($urandom % 10) == 0;
      i_ex2_l1d_hit      = hit;
      i_ex2_l1d_conflict = conflict;
      if (req_valid && hit) begin
        for (int j = 0; j < DCACHE_DATA_B_W; j++)
          i_ex2_l1d_data[j*8 +: 8] = mem_byte(req_paddr + paddr_t'(j));
      end else begin
        i_ex2_l1d_data = {$urandom, $urandom, $urandom, $urandom};  // Junk on a miss
      end
      if (($urandom % 4) == 0)
        i_ex2_stq_fwd_dw = model_dw(m_ex2);
      else
        i_ex2_stq_fwd_dw = byte_en_t'($urandom & $urandom);
      i_ex2_stq_fwd_data   = {$urandom, $urandom};
      i_ex2_stbuf_fwd_dw   = byte_en_t'($urandom & $urandom);
      i_ex2_stbuf_fwd_data = {$urandom, $urandom};
      #1;

      // EX0 selection
      check_value("o_ex0_rs_conflicted", o_ex0_rs_conflicted, new_replay.valid & m_ex0.valid);
      if (new_replay.valid && m_ex0.valid)
        check_value("o_ex0_rs_conf_index_oh", o_ex0_rs_conf_index_oh, m_ex0.rsidx);

      // EX1
      m_ex1.paddr = model_paddr(m_ex1);
      check_value("o_ex1_upd_valid", o_ex1_upd_valid, m_ex1.valid);
      check_value("o_ex1_l1d_valid", o_ex1_l1d_valid, m_ex1.valid & !is_store(m_ex1.inst));
      if (m_ex1.valid) begin
        check_value("o_ex1_upd_index_oh", o_ex1_upd_index_oh, m_ex1.qidx);
        check_value("o_ex1_rs1_rnid", o_ex1_rs1_rnid, m_ex1.rs1);
        check_value("o_ex1_rs2_rnid", o_ex1_rs2_rnid, m_ex1.rs2);
        check_value("o_ex1_upd_paddr", o_ex1_upd_paddr, m_ex1.paddr);
        check_value("o_ex1_upd_size", o_ex1_upd_size, m_ex1.inst[13:12]);
        if (is_store(m_ex1.inst))
          check_value("o_ex1_upd_st_data", o_ex1_upd_st_data, regs[m_ex1.rs2]);
        else
          check_value("o_ex1_l1d_paddr", o_ex1_l1d_paddr, {m_ex1.paddr[PADDR_W-1:4], 4'h0});
      end

      // EX2
      load2   = m_ex2.valid & !is_store(m_ex2.inst);
      conf2   = load2 & conflict;
      miss2   = load2 & !hit & !conflict & (i_ex2_stq_fwd_dw != model_dw(m_ex2));
      exp_haz = conf2 ? 2'd1 : (miss2 ? 2'd2 : 2'd0);
      check_value("o_ex2_upd_valid", o_ex2_upd_valid, m_ex2.valid);
      check_value("o_ex2_fwd_valid", o_ex2_fwd_valid, load2);
      check_value("o_ex2_upd_hazard", o_ex2_upd_hazard, exp_haz);
      check_value("o_ex2_mispred_valid", o_ex2_mispred_valid, conf2 | miss2);
      if (m_ex2.valid)
        check_value("o_ex2_upd_index_oh", o_ex2_upd_index_oh, m_ex2.qidx);
      if (load2) begin
        check_value("o_ex2_fwd_paddr", o_ex2_fwd_paddr, m_ex2.paddr);
        check_value("o_ex2_fwd_dw", o_ex2_fwd_dw, model_dw(m_ex2));
      end
      if (conf2 || miss2)
        check_value("o_ex2_mispred_rnid", o_ex2_mispred_rnid, m_ex2.rd);

      // EX3
      check_value("o_ex3_done", o_ex3_done, m_ex3_done);
      check_value("o_ex3_wr_valid", o_ex3_wr_valid, m_ex3_wr);
      if (m_ex3_wr) begin
        check_value("o_ex3_wr_rnid", o_ex3_wr_rnid, m_ex3_rd);
        check_value("o_ex3_wr_data", o_ex3_wr_data, m_ex3_data);
      end

      req_valid = o_ex1_l1d_valid;
      req_paddr = o_ex1_l1d_paddr;

      // Advance the pipeline model
      m_ex3_done = m_ex2.valid & !(conf2 | miss2);
      m_ex3_wr   = load2 & !(conf2 | miss2) & (m_ex2.inst[11:7] != 5'd0);
      m_ex3_rd   = m_ex2.rd;
      m_ex3_data = model_load(m_ex2, i_ex2_stq_fwd_dw, i_ex2_stq_fwd_data,
                              i_ex2_stbuf_fwd_dw, i_ex2_stbuf_fwd_data);
      m_ex2      = m_ex1;
      if (new_replay.valid) begin
        sel = new_replay;
      end else begin
        sel      = m_ex0;
        sel.qidx = '0;  // Fresh issue owns no queue entry yet
      end
      m_ex1 = sel;
      m_ex0 = new_issue;
      @(negedge i_clk);
    end

    if (err_count == 0 && lsu_pipe_i.u_props.n_fail == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/lsu_pipe_props.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_pipe_props
  import lsu_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_replay_valid,
  input  mem_q_oh_t i_replay_index_oh,
  input  logic      o_ex0_rs_conflicted,
  input  mem_q_oh_t o_ex1_upd_index_oh,
  input  logic      o_ex1_l1d_valid,
  input  logic      o_ex1_upd_valid,
  input  logic      o_ex2_fwd_valid,
  input  logic      o_ex2_upd_valid,
  input  logic      o_ex2_mispred_valid,
  input  logic      o_ex3_done,
  input  logic      o_ex3_wr_valid
);

  int n_fail = 0;  // Read by the testbench at the end

  a_ex1_index_onehot0 : assert property (
    @(posedge i_clk) disable iff (!i_reset_n) $onehot0(o_ex1_upd_index_oh))
    else begin
      $error("EX1 queue index has more than one bit set");
      n_fail++;
    end

  // The replay takes EX1 in place of the conflicted issue
  a_conflict_needs_replay : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_ex0_rs_conflicted |-> i_replay_valid
                            ##1 (o_ex1_upd_valid &&
                                 o_ex1_upd_index_oh == $past(i_replay_index_oh)))
    else begin
      $error("RS conflict reported without the replay entering EX1");
      n_fail++;
    end

  // No strobe may leak out while reset is held
  a_valids_low_in_reset : assert property (
    @(posedge i_clk) !i_reset_n |-> !(o_ex0_rs_conflicted | o_ex1_l1d_valid | o_ex1_upd_valid |
                                      o_ex2_fwd_valid | o_ex2_upd_valid | o_ex2_mispred_valid |
                                      o_ex3_done | o_ex3_wr_valid))
    else begin
      $error("Valid output high during reset");
      n_fail++;
    end

endmodule

bind lsu_pipe lsu_pipe_props u_props (
  .i_clk               (i_clk),
  .i_reset_n           (i_reset_n),
  .i_replay_valid      (i_replay_valid),
  .i_replay_index_oh   (i_replay_index_oh),
  .o_ex0_rs_conflicted (o_ex0_rs_conflicted),
  .o_ex1_upd_index_oh  (o_ex1_upd_index_oh),
  .o_ex1_l1d_valid     (o_ex1_l1d_valid),
  .o_ex1_upd_valid     (o_ex1_upd_valid),
  .o_ex2_fwd_valid     (o_ex2_fwd_valid),
  .o_ex2_upd_valid     (o_ex2_upd_valid),
  .o_ex2_mispred_valid (o_ex2_mispred_valid),
  .o_ex3_done          (o_ex3_done),
  .o_ex3_wr_valid      (o_ex3_wr_valid)
);

`default_nettype wire

/* source/lsu_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_pipe
  import lsu_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,

  input  logic      i_rv_valid,
  input  inst_t     i_rv_inst,
  input  rnid_t     i_rv_rs1_rnid,
  input  rnid_t     i_rv_rs2_rnid,
  input  rnid_t     i_rv_rd_rnid,
  input  rs_oh_t    i_rv_index_oh,

  input  logic      i_replay_valid,
  input  inst_t     i_replay_inst,
  input  rnid_t     i_replay_rs1_rnid,
  input  rnid_t     i_replay_rs2_rnid,
  input  rnid_t     i_replay_rd_rnid,
  input  mem_q_oh_t i_replay_index_oh,

  output logic      o_ex0_rs_conflicted,
  output rs_oh_t    o_ex0_rs_conf_index_oh,

  // Register read
  output rnid_t     o_ex1_rs1_rnid,
  input  xlen_t     i_ex1_rs1_data,
  output rnid_t     o_ex1_rs2_rnid,
  input  xlen_t     i_ex1_rs2_data,

  // L1D
  output logic      o_ex1_l1d_valid,
  output paddr_t    o_ex1_l1d_paddr,
  input  logic      i_ex2_l1d_hit,
  input  logic      i_ex2_l1d_conflict,
  input  line_t     i_ex2_l1d_data,

  output logic      o_ex1_upd_valid,
  output mem_q_oh_t o_ex1_upd_index_oh,
  output paddr_t    o_ex1_upd_paddr,
  output size_e     o_ex1_upd_size,
  output xlen_t     o_ex1_upd_st_data,

  // Forwarding
  output logic      o_ex2_fwd_valid,
  output paddr_t    o_ex2_fwd_paddr,
  output byte_en_t  o_ex2_fwd_dw,
  input  byte_en_t  i_ex2_stq_fwd_dw,
  input  xlen_t     i_ex2_stq_fwd_data,
  input  byte_en_t  i_ex2_stbuf_fwd_dw,
  input  xlen_t     i_ex2_stbuf_fwd_data,

  output logic      o_ex2_upd_valid,
  output mem_q_oh_t o_ex2_upd_index_oh,
  output hazard_e   o_ex2_upd_hazard,
  output logic      o_ex2_mispred_valid,
  output rnid_t     o_ex2_mispred_rnid,

  output logic      o_ex3_done,
  output logic      o_ex3_wr_valid,
  output rnid_t     o_ex3_wr_rnid,
  output xlen_t     o_ex3_wr_data
);

  logic     w_ex1_valid;
  inst_t    w_ex1_inst;
  paddr_t   w_ex2_paddr;
  size_e    w_ex2_size;
  logic     w_ex2_sign;
  byte_en_t w_ex2_dw;
  byte_en_t w_stq_dw;
  xlen_t    w_stq_data;
  byte_en_t w_stbuf_dw;
  xlen_t    w_stbuf_data;

  assign o_ex1_upd_valid = w_ex1_valid;  // Every item updates its queue entry
  assign o_ex2_fwd_paddr = w_ex2_paddr;
  assign o_ex2_fwd_dw    = w_ex2_dw;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  lsu_pipe_ctrl u_ctrl (
    .i_clk                  (i_clk),
    .i_reset_n              (i_reset_n),
    .i_rv_valid             (i_rv_valid),
    .i_rv_inst              (i_rv_inst),
    .i_rv_rs1_rnid          (i_rv_rs1_rnid),
    .i_rv_rs2_rnid          (i_rv_rs2_rnid),
    .i_rv_rd_rnid           (i_rv_rd_rnid),
    .i_rv_index_oh          (i_rv_index_oh),
    .i_replay_valid         (i_replay_valid),
    .i_replay_inst          (i_replay_inst),
    .i_replay_rs1_rnid      (i_replay_rs1_rnid),
    .i_replay_rs2_rnid      (i_replay_rs2_rnid),
    .i_replay_rd_rnid       (i_replay_rd_rnid),
    .i_replay_index_oh      (i_replay_index_oh),
    .o_ex0_rs_conflicted    (o_ex0_rs_conflicted),
    .o_ex0_rs_conf_index_oh (o_ex0_rs_conf_index_oh),
    .o_ex1_valid            (w_ex1_valid),
    .o_ex1_inst             (w_ex1_inst),
    .o_ex1_rs1_rnid         (o_ex1_rs1_rnid),
    .o_ex1_rs2_rnid         (o_ex1_rs2_rnid),
    .o_ex1_index_oh         (o_ex1_upd_index_oh),
    .i_ex2_dw               (w_ex2_dw),
    .i_ex2_l1d_hit          (i_ex2_l1d_hit),
    .i_ex2_l1d_conflict     (i_ex2_l1d_conflict),
    .i_ex2_stq_fwd_dw       (i_ex2_stq_fwd_dw),
    .o_ex2_valid            (),
    .o_ex2_fwd_valid        (o_ex2_fwd_valid),
    .o_ex2_upd_valid        (o_ex2_upd_valid),
    .o_ex2_upd_index_oh     (o_ex2_upd_index_oh),
    .o_ex2_upd_hazard       (o_ex2_upd_hazard),
    .o_ex2_mispred_valid    (o_ex2_mispred_valid),
    .o_ex2_mispred_rnid     (o_ex2_mispred_rnid),
    .o_ex3_done             (o_ex3_done),
    .o_ex3_wr_valid         (o_ex3_wr_valid),
    .o_ex3_wr_rnid          (o_ex3_wr_rnid)
  );

  // ----------------------------------------
  // Datapath
  // ----------------------------------------
  lsu_agen u_agen (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_ex1_valid       (w_ex1_valid),
    .i_ex1_inst        (w_ex1_inst),
    .i_ex1_rs1_data    (i_ex1_rs1_data),
    .i_ex1_rs2_data    (i_ex1_rs2_data),
    .o_ex1_l1d_valid   (o_ex1_l1d_valid),
    .o_ex1_l1d_paddr   (o_ex1_l1d_paddr),
    .o_ex1_upd_paddr   (o_ex1_upd_paddr),
    .o_ex1_upd_size    (o_ex1_upd_size),
    .o_ex1_upd_st_data (o_ex1_upd_st_data),
    .o_ex2_paddr       (w_ex2_paddr),
    .o_ex2_size        (w_ex2_size),
    .o_ex2_sign        (w_ex2_sign),
    .o_ex2_dw          (w_ex2_dw)
  );

  lsu_fwd_align u_stq_align (
    .i_size     (w_ex2_size),
    .i_offset   (w_ex2_paddr[2:0]),
    .i_fwd_dw   (i_ex2_stq_fwd_dw),
    .i_fwd_data (i_ex2_stq_fwd_data),
    .o_dw       (w_stq_dw),
    .o_data     (w_stq_data)
  );

  lsu_fwd_align u_stbuf_align (
    .i_size     (w_ex2_size),
    .i_offset   (w_ex2_paddr[2:0]),
    .i_fwd_dw   (i_ex2_stbuf_fwd_dw),
    .i_fwd_data (i_ex2_stbuf_fwd_data),
    .o_dw       (w_stbuf_dw),
    .o_data     (w_stbuf_data)
  );

  lsu_load_format u_load_format (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_ex2_paddr  (w_ex2_paddr),
    .i_ex2_size   (w_ex2_size),
    .i_ex2_sign   (w_ex2_sign),
    .i_l1d_data   (i_ex2_l1d_data),
    .i_stq_dw     (w_stq_dw),
    .i_stq_data   (w_stq_data),
    .i_stbuf_dw   (w_stbuf_dw),
    .i_stbuf_data (w_stbuf_data),
    .o_ex3_data   (o_ex3_wr_data)
  );

endmodule

`default_nettype wire

/* source/lsu_load_format.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_load_format
  import lsu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,

  input  paddr_t   i_ex2_paddr,
  input  size_e    i_ex2_size,
  input  logic     i_ex2_sign,
  input  line_t    i_l1d_data,

  input  byte_en_t i_stq_dw,     // Already aligned to the access
  input  xlen_t    i_stq_data,
  input  byte_en_t i_stbuf_dw,
  input  xlen_t    i_stbuf_data,

  output xlen_t    o_ex3_data
);

  line_t w_line_shifted;
  xlen_t w_l1d_dw;
  xlen_t w_merged;
  xlen_t w_result;

  assign w_line_shifted = i_l1d_data >> {i_ex2_paddr[$clog2(DCACHE_DATA_B_W)-1:0], 3'b000};
  assign w_l1d_dw       = w_line_shifted[XLEN_W-1:0];

  // ----------------------------------------
  // Byte merge, STQ over STBUF over L1D
  // ----------------------------------------
  always_comb begin
    for (int b = 0; b < XLEN_W / 8; b++) begin
      w_merged[b*8 +: 8] = i_stq_dw[b]   ? i_stq_data[b*8 +: 8]   :
                           i_stbuf_dw[b] ? i_stbuf_data[b*8 +: 8] :
                                           w_l1d_dw[b*8 +: 8];
    end
  end

  always_comb begin
    case (i_ex2_size)
      SIZE_B:  w_result = {{(XLEN_W-8){i_ex2_sign & w_merged[7]}}, w_merged[7:0]};
      SIZE_H:  w_result = {{(XLEN_W-16){i_ex2_sign & w_merged[15]}}, w_merged[15:0]};
      SIZE_W:  w_result = {{(XLEN_W-32){i_ex2_sign & w_merged[31]}}, w_merged[31:0]};
      default: w_result = w_merged;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex3_data <= '0;
    end else begin
      o_ex3_data <= w_result;
    end
  end

endmodule

`default_nettype wire

/* source/lsu_fwd_align.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_fwd_align
  import lsu_pkg::*;
(
  input  size_e      i_size,
  input  logic [2:0] i_offset,
  input  byte_en_t   i_fwd_dw,
  input  xlen_t      i_fwd_data,
  output byte_en_t   o_dw,
  output xlen_t      o_data
);

  logic [2:0] w_shift;  // In bytes

  // Offset rounded down to the access size
  always_comb begin
    case (i_size)
      SIZE_W:  w_shift = {i_offset[2], 2'b00};
      SIZE_H:  w_shift = {i_offset[2:1], 1'b0};
      SIZE_B:  w_shift = i_offset;
      default: w_shift = 3'd0;
    endcase
  end

  assign o_dw   = i_fwd_dw >> w_shift;
  assign o_data = i_fwd_data >> {w_shift, 3'b000};

endmodule

`default_nettype wire

/* source/lsu_agen.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_agen
  import lsu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,

  input  logic     i_ex1_valid,
  input  inst_t    i_ex1_inst,
  input  xlen_t    i_ex1_rs1_data,
  input  xlen_t    i_ex1_rs2_data,

  output logic     o_ex1_l1d_valid,
  output paddr_t   o_ex1_l1d_paddr,
  output paddr_t   o_ex1_upd_paddr,
  output size_e    o_ex1_upd_size,
  output xlen_t    o_ex1_upd_st_data,

  output paddr_t   o_ex2_paddr,
  output size_e    o_ex2_size,
  output logic     o_ex2_sign,
  output byte_en_t o_ex2_dw
);

  size_e  w_ex1_size;
  logic   w_ex1_sign;
  op_e    w_ex1_op;
  xlen_t  w_ex1_imm;
  xlen_t  w_ex1_addr;
  paddr_t w_ex1_paddr;

  always_comb begin
    lsu_decode(i_ex1_inst, w_ex1_size, w_ex1_sign, w_ex1_op);
  end

  // S-type immediate is split around the rd field
  assign w_ex1_imm = (w_ex1_op == OP_STORE) ?
                     {{(XLEN_W-12){i_ex1_inst[31]}}, i_ex1_inst[31:25], i_ex1_inst[11:7]} :
                     {{(XLEN_W-12){i_ex1_inst[31]}}, i_ex1_inst[31:20]};

  assign w_ex1_addr  = i_ex1_rs1_data + w_ex1_imm;
  assign w_ex1_paddr = w_ex1_addr[PADDR_W-1:0];  // No translation

  // ----------------------------------------
  // L1D request and queue update
  // ----------------------------------------
  assign o_ex1_l1d_valid = i_ex1_valid & (w_ex1_op == OP_LOAD);
  assign o_ex1_l1d_paddr = {w_ex1_paddr[PADDR_W-1:$clog2(DCACHE_DATA_B_W)],
                            {$clog2(DCACHE_DATA_B_W){1'b0}}};

  assign o_ex1_upd_paddr   = w_ex1_paddr;
  assign o_ex1_upd_size    = w_ex1_size;
  assign o_ex1_upd_st_data = i_ex1_rs2_data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex2_paddr <= '0;
      o_ex2_size  <= SIZE_B;
      o_ex2_sign  <= 1'b0;
      o_ex2_dw    <= '0;
    end else begin
      o_ex2_paddr <= w_ex1_paddr;
      o_ex2_size  <= w_ex1_size;
      o_ex2_sign  <= w_ex1_sign;
      o_ex2_dw    <= gen_dw(w_ex1_size, w_ex1_paddr[2:0]);
    end
  end

endmodule

`default_nettype wire

/* source/lsu_pipe_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_pipe_ctrl
  import lsu_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,

  input  logic      i_rv_valid,
  input  inst_t     i_rv_inst,
  input  rnid_t     i_rv_rs1_rnid,
  input  rnid_t     i_rv_rs2_rnid,
  input  rnid_t     i_rv_rd_rnid,
  input  rs_oh_t    i_rv_index_oh,

  input  logic      i_replay_valid,
  input  inst_t     i_replay_inst,
  input  rnid_t     i_replay_rs1_rnid,
  input  rnid_t     i_replay_rs2_rnid,
  input  rnid_t     i_replay_rd_rnid,
  input  mem_q_oh_t i_replay_index_oh,

  output logic      o_ex0_rs_conflicted,
  output rs_oh_t    o_ex0_rs_conf_index_oh,

  output logic      o_ex1_valid,
  output inst_t     o_ex1_inst,
  output rnid_t     o_ex1_rs1_rnid,
  output rnid_t     o_ex1_rs2_rnid,
  output mem_q_oh_t o_ex1_index_oh,

  input  byte_en_t  i_ex2_dw,
  input  logic      i_ex2_l1d_hit,
  input  logic      i_ex2_l1d_conflict,
  input  byte_en_t  i_ex2_stq_fwd_dw,
  output logic      o_ex2_valid,
  output logic      o_ex2_fwd_valid,
  output logic      o_ex2_upd_valid,
  output mem_q_oh_t o_ex2_upd_index_oh,
  output hazard_e   o_ex2_upd_hazard,
  output logic      o_ex2_mispred_valid,
  output rnid_t     o_ex2_mispred_rnid,

  output logic      o_ex3_done,
  output logic      o_ex3_wr_valid,
  output rnid_t     o_ex3_wr_rnid
);

  logic      r_ex0_valid;
  inst_t     r_ex0_inst;
  rnid_t     r_ex0_rs1_rnid;
  rnid_t     r_ex0_rs2_rnid;
  rnid_t     r_ex0_rd_rnid;
  rs_oh_t    r_ex0_index_oh;

  logic      w_ex0_valid;
  inst_t     w_ex0_inst;
  rnid_t     w_ex0_rs1_rnid;
  rnid_t     w_ex0_rs2_rnid;
  rnid_t     w_ex0_rd_rnid;
  mem_q_oh_t w_ex0_index_oh;

  logic      r_ex1_valid;
  inst_t     r_ex1_inst;
  rnid_t     r_ex1_rs1_rnid;
  rnid_t     r_ex1_rs2_rnid;
  rnid_t     r_ex1_rd_rnid;
  mem_q_oh_t r_ex1_index_oh;
  op_e       w_ex1_op;

  logic      r_ex2_valid;
  op_e       r_ex2_op;
  logic      r_ex2_rd_nz;
  rnid_t     r_ex2_rd_rnid;
  mem_q_oh_t r_ex2_index_oh;
  logic      w_ex2_load;
  logic      w_ex2_conflict;
  logic      w_ex2_miss;
  logic      w_ex2_mispred;

  logic      r_ex3_valid;
  logic      r_ex3_wr_valid;
  rnid_t     r_ex3_rd_rnid;

  // ----------------------------------------
  // EX0 select, replay has priority
  // ----------------------------------------
  assign w_ex0_valid    = i_replay_valid | r_ex0_valid;
  assign w_ex0_inst     = i_replay_valid ? i_replay_inst     : r_ex0_inst;
  assign w_ex0_rs1_rnid = i_replay_valid ? i_replay_rs1_rnid : r_ex0_rs1_rnid;
  assign w_ex0_rs2_rnid = i_replay_valid ? i_replay_rs2_rnid : r_ex0_rs2_rnid;
  assign w_ex0_rd_rnid  = i_replay_valid ? i_replay_rd_rnid  : r_ex0_rd_rnid;
  assign w_ex0_index_oh = i_replay_valid ? i_replay_index_oh : '0;  // New issue has no queue slot

  assign o_ex0_rs_conflicted    = i_replay_valid & r_ex0_valid;
  assign o_ex0_rs_conf_index_oh = r_ex0_index_oh;

  // Only the operation is needed here
  always_comb begin
    size_e ex1_size;
    logic  ex1_sign;
    lsu_decode(r_ex1_inst, ex1_size, ex1_sign, w_ex1_op);
  end

  // ----------------------------------------
  // EX2 hazard and misprediction
  // ----------------------------------------
  assign w_ex2_load     = r_ex2_valid & (r_ex2_op == OP_LOAD);
  assign w_ex2_conflict = w_ex2_load & i_ex2_l1d_conflict;
  // Miss is fine only if the STQ supplies every byte
  assign w_ex2_miss     = w_ex2_load & ~i_ex2_l1d_hit & ~i_ex2_l1d_conflict &
                          (i_ex2_stq_fwd_dw != i_ex2_dw);
  assign w_ex2_mispred  = w_ex2_conflict | w_ex2_miss;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid    <= 1'b0;
      r_ex0_inst     <= '0;
      r_ex0_rs1_rnid <= '0;
      r_ex0_rs2_rnid <= '0;
      r_ex0_rd_rnid  <= '0;
      r_ex0_index_oh <= '0;
      r_ex1_valid    <= 1'b0;
      r_ex1_inst     <= '0;
      r_ex1_rs1_rnid <= '0;
      r_ex1_rs2_rnid <= '0;
      r_ex1_rd_rnid  <= '0;
      r_ex1_index_oh <= '0;
      r_ex2_valid    <= 1'b0;
      r_ex2_op       <= OP_LOAD;
      r_ex2_rd_nz    <= 1'b0;
      r_ex2_rd_rnid  <= '0;
      r_ex2_index_oh <= '0;
      r_ex3_valid    <= 1'b0;
      r_ex3_wr_valid <= 1'b0;
      r_ex3_rd_rnid  <= '0;
    end else begin
      r_ex0_valid    <= i_rv_valid;
      r_ex0_inst     <= i_rv_inst;
      r_ex0_rs1_rnid <= i_rv_rs1_rnid;
      r_ex0_rs2_rnid <= i_rv_rs2_rnid;
      r_ex0_rd_rnid  <= i_rv_rd_rnid;
      r_ex0_index_oh <= i_rv_index_oh;

      r_ex1_valid    <= w_ex0_valid;
      r_ex1_inst     <= w_ex0_inst;
      r_ex1_rs1_rnid <= w_ex0_rs1_rnid;
      r_ex1_rs2_rnid <= w_ex0_rs2_rnid;
      r_ex1_rd_rnid  <= w_ex0_rd_rnid;
      r_ex1_index_oh <= w_ex0_index_oh;

      r_ex2_valid    <= r_ex1_valid;
      r_ex2_op       <= w_ex1_op;
      r_ex2_rd_nz    <= r_ex1_inst[11:7] != 5'd0;  // x0 is never written
      r_ex2_rd_rnid  <= r_ex1_rd_rnid;
      r_ex2_index_oh <= r_ex1_index_oh;

      r_ex3_valid    <= r_ex2_valid & ~w_ex2_mispred;
      r_ex3_wr_valid <= w_ex2_load & r_ex2_rd_nz & ~w_ex2_mispred;
      r_ex3_rd_rnid  <= r_ex2_rd_rnid;
    end
  end

  assign o_ex1_valid    = r_ex1_valid;
  assign o_ex1_inst     = r_ex1_inst;
  assign o_ex1_rs1_rnid = r_ex1_rs1_rnid;
  assign o_ex1_rs2_rnid = r_ex1_rs2_rnid;
  assign o_ex1_index_oh = r_ex1_index_oh;

  assign o_ex2_valid         = r_ex2_valid;
  assign o_ex2_fwd_valid     = w_ex2_load;
  assign o_ex2_upd_valid     = r_ex2_valid;
  assign o_ex2_upd_index_oh  = r_ex2_index_oh;
  assign o_ex2_upd_hazard    = w_ex2_conflict ? L1D_CONFLICT :
                               w_ex2_miss     ? L1D_MISS     : NONE;
  assign o_ex2_mispred_valid = w_ex2_mispred;
  assign o_ex2_mispred_rnid  = r_ex2_rd_rnid;

  assign o_ex3_done     = r_ex3_valid;
  assign o_ex3_wr_valid = r_ex3_wr_valid;
  assign o_ex3_wr_rnid  = r_ex3_rd_rnid;

endmodule

`default_nettype wire

/* source/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  localparam int XLEN_W          = 64;
  localparam int PADDR_W         = 40;
  localparam int DCACHE_DATA_B_W = 16;  // L1D line in bytes
  localparam int RNID_W          = 6;
  localparam int MEM_Q_SIZE      = 16;
  localparam int RV_ENTRY_SIZE   = 32;

  typedef logic [XLEN_W-1:0]            xlen_t;
  typedef logic [PADDR_W-1:0]           paddr_t;
  typedef logic [DCACHE_DATA_B_W*8-1:0] line_t;
  typedef logic [XLEN_W/8-1:0]          byte_en_t;
  typedef logic [31:0]                  inst_t;
  typedef logic [RNID_W-1:0]            rnid_t;
  typedef logic [MEM_Q_SIZE-1:0]        mem_q_oh_t;
  typedef logic [RV_ENTRY_SIZE-1:0]     rs_oh_t;

  typedef enum logic [1:0] {
    SIZE_B  = 2'd0,
    SIZE_H  = 2'd1,
    SIZE_W  = 2'd2,
    SIZE_DW = 2'd3
  } size_e;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_e;

  typedef enum logic [1:0] {
    NONE         = 2'd0,
    L1D_CONFLICT = 2'd1,
    L1D_MISS     = 2'd2
  } hazard_e;

  // funct3[1:0] gives the size, funct3[2] marks an unsigned load
  function automatic void lsu_decode(input inst_t inst, output size_e size,
                                     output logic sign, output op_e op);
    size = size_e'(inst[13:12]);
    sign = ~inst[14];
    op   = inst[5] ? OP_STORE : OP_LOAD;  // STORE opcode is 0100011
  endfunction

  function automatic byte_en_t gen_dw(input size_e size, input logic [2:0] offset);
    byte_en_t base;
    case (size)
      SIZE_B:  base = 8'h01;
      SIZE_H:  base = 8'h03;
      SIZE_W:  base = 8'h0f;
      default: base = 8'hff;
    endcase
    return base << offset;
  endfunction

endpackage

`default_nettype wire
